/* run_sim.sh */
#!/bin/sh
# Builds the FIFO testbench with Verilator, runs it and scans the log.
# Exits with 1 when the log holds the fail line or lacks the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_dcfifo \
    -Mdir obj_dir -o sim_dcfifo -f verilog.f || exit 1
./obj_dir/sim_dcfifo > sim.log 2>&1
cat sim.log
grep -qF "*** TEST FAILED ***" sim.log && echo "Simulation reported a failure" && exit 1
grep -qF "*** TEST PASSED ***" sim.log || { echo "No pass line in sim.log"; exit 1; }
exit 0

/* src/dcfifo_config.svh */
/*
 * Size constants for the dual-clock stream FIFO.
 * Included by the packages and by RTL files that slice pointers.
 */
`ifndef DCFIFO_CONFIG_SVH
`define DCFIFO_CONFIG_SVH

// Stored word width
`define DCFIFO_DATA_WIDTH 8

// Address bits, depth is 2**DCFIFO_ADDR_WIDTH
`define DCFIFO_ADDR_WIDTH 4

// Flops in each pointer synchronizer
`define DCFIFO_SYNC_DEPTH 2

// CSR bus and level field widths
`define DCFIFO_CSR_WIDTH 32
`define DCFIFO_THRESH_WIDTH 24

`endif

/* src/dcfifo_csr_pkg.sv */
/*
 * Types of the per-side CSR port and streaming status compare.
 */
`default_nettype none

`include "dcfifo_config.svh"

package dcfifo_csr_pkg;

    typedef enum logic {
        CSR_FILL_LEVEL = 1'b0,
        CSR_THRESHOLD  = 1'b1
    } csr_addr_e;

    typedef logic [`DCFIFO_CSR_WIDTH-1:0] csr_word_t;
    typedef logic [`DCFIFO_THRESH_WIDTH-1:0] threshold_t;

    // Status rule of one CSR port
    typedef enum logic {
        CMP_AT_OR_ABOVE,
        CMP_AT_OR_BELOW
    } thresh_cmp_e;

endpackage

`default_nettype wire

/* src/dcfifo_pkg.sv */
/*
 * Types of the FIFO core: stored word, pointers, addresses and levels.
 * Referenced by scoped name from the RTL and the testbench.
 */
`default_nettype none

`include "dcfifo_config.svh"

package dcfifo_pkg;

    // One stored word
    typedef logic [`DCFIFO_DATA_WIDTH-1:0] data_t;

    // Pointer with one extra wrap bit, binary or Gray
    typedef logic [`DCFIFO_ADDR_WIDTH:0] ptr_t;

    // Memory address
    typedef logic [`DCFIFO_ADDR_WIDTH-1:0] addr_t;

    // Fill level, the output side can reach depth plus one
    typedef logic [`DCFIFO_ADDR_WIDTH:0] level_t;

endpackage

`default_nettype wire

/* src/dcfifo_ram.sv */
/*
 * Storage of the FIFO. Written on the input clock, read into a
 * register on every output clock edge.
 */
`timescale 1ns/1ps
`default_nettype none

module dcfifo_ram (
    input  logic                wr_clk,
    input  logic                rd_clk,
    input  logic                wr_en,
    input  dcfifo_pkg::addr_t   wr_addr,
    input  dcfifo_pkg::data_t   wr_data,
    input  dcfifo_pkg::addr_t   rd_addr,
    output dcfifo_pkg::data_t   rd_data
);

    localparam int DEPTH = 2 ** $bits(dcfifo_pkg::addr_t);

    dcfifo_pkg::data_t mem [DEPTH];

    always_ff @(posedge wr_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge rd_clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

/* src/dcfifo_read_side.sv */
/*
 * Output clock domain of the FIFO: read pointer, empty flag, output stage
 * and output fill level. The write pointer arrives synchronized and in binary.
 */
`timescale 1ns/1ps
`default_nettype none

`include "dcfifo_config.svh"

module dcfifo_read_side (
    input  logic                out_clk,
    input  logic                out_reset_n,
    input  dcfifo_pkg::ptr_t    wr_ptr_sync,
    output dcfifo_pkg::ptr_t    rd_ptr_next,
    output dcfifo_pkg::addr_t   rd_addr,
    input  dcfifo_pkg::data_t   ram_data,
    output dcfifo_pkg::data_t   out_data,
    output logic                out_valid,
    input  logic                out_ready,
    output dcfifo_pkg::level_t  fill_level
);

    dcfifo_pkg::ptr_t   rd_ptr;
    dcfifo_pkg::level_t fifo_level;
    logic               empty;
    logic               mem_valid;
    logic               stage_ready;
    logic               mem_pop;

    assign mem_valid   = !empty;
    // Stage takes a word when it is empty or being drained
    assign stage_ready = out_ready || !out_valid;
    assign mem_pop     = mem_valid && stage_ready;

    assign rd_ptr_next = rd_ptr + dcfifo_pkg::ptr_t'(mem_pop);
    // The memory registers the next address, so its output matches rd_ptr
    assign rd_addr     = rd_ptr_next[`DCFIFO_ADDR_WIDTH-1:0];

    // --------------------
    // Pointer and empty
    // --------------------
    always_ff @(posedge out_clk or negedge out_reset_n) begin
        if (!out_reset_n) begin
            rd_ptr     <= '0;
            empty      <= 1'b1;
            fifo_level <= '0;
        end else begin
            rd_ptr     <= rd_ptr_next;
            empty      <= (rd_ptr_next == wr_ptr_sync);
            fifo_level <= wr_ptr_sync - rd_ptr_next;
        end
    end

    // --------------------
    // Output stage
    // --------------------
    always_ff @(posedge out_clk or negedge out_reset_n) begin
        if (!out_reset_n) begin
            out_valid <= 1'b0;
        end else if (stage_ready) begin
            out_valid <= mem_valid;
        end
    end

    always_ff @(posedge out_clk) begin
        if (stage_ready) begin
            out_data <= ram_data;
        end
    end

    // Full FIFO with a held word reads depth plus one
    assign fill_level = fifo_level + dcfifo_pkg::level_t'(out_valid);

endmodule

`default_nettype wire

/* src/dcfifo_top.sv */
/*
 * Dual-clock stream FIFO, 16 words deep, with a CSR port and a status bit per side.
 * Sink, in CSR and almost-full are on in_clk; source, out CSR and almost-empty on out_clk.
 */
`timescale 1ns/1ps
`default_nettype none

`include "dcfifo_config.svh"

module dcfifo_top (
    input  logic                        in_clk,
    input  logic                        in_reset_n,
    input  logic                        out_clk,
    input  logic                        out_reset_n,
    // Sink
    input  dcfifo_pkg::data_t           in_data,
    input  logic                        in_valid,
    output logic                        in_ready,
    // Source
    output dcfifo_pkg::data_t           out_data,
    output logic                        out_valid,
    input  logic                        out_ready,
    // In CSR
    input  dcfifo_csr_pkg::csr_addr_e   in_csr_address,
    input  logic                        in_csr_read,
    input  logic                        in_csr_write,
    input  dcfifo_csr_pkg::csr_word_t   in_csr_writedata,
    output dcfifo_csr_pkg::csr_word_t   in_csr_readdata,
    // Out CSR
    input  dcfifo_csr_pkg::csr_addr_e   out_csr_address,
    input  logic                        out_csr_read,
    input  logic                        out_csr_write,
    input  dcfifo_csr_pkg::csr_word_t   out_csr_writedata,
    output dcfifo_csr_pkg::csr_word_t   out_csr_readdata,
    // Streaming status
    output logic                        almost_full_valid,
    output logic                        almost_full_data,
    output logic                        almost_empty_valid,
    output logic                        almost_empty_data
);

    dcfifo_pkg::ptr_t   wr_ptr;
    dcfifo_pkg::ptr_t   wr_ptr_out;
    dcfifo_pkg::ptr_t   rd_ptr_next;
    dcfifo_pkg::ptr_t   rd_ptr_in;
    dcfifo_pkg::addr_t  wr_addr;
    dcfifo_pkg::addr_t  rd_addr;
    dcfifo_pkg::data_t  ram_data;
    dcfifo_pkg::level_t in_level;
    dcfifo_pkg::level_t out_level;
    logic               wr_en;

    dcfifo_write_side i_write_side (
        .in_clk      (in_clk),
        .in_reset_n  (in_reset_n),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .rd_ptr_sync (rd_ptr_in),
        .wr_ptr      (wr_ptr),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .fill_level  (in_level)
    );

    dcfifo_ram i_ram (
        .wr_clk  (in_clk),
        .rd_clk  (out_clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (in_data),
        .rd_addr (rd_addr),
        .rd_data (ram_data)
    );

    // --------------------
    // Pointer crossings
    // --------------------
    gray_ptr_sync #(.SYNC_DEPTH(`DCFIFO_SYNC_DEPTH)) wr_crosser (
        .src_clk     (in_clk),
        .src_reset_n (in_reset_n),
        .dst_clk     (out_clk),
        .dst_reset_n (out_reset_n),
        .src_ptr     (wr_ptr),
        .dst_ptr     (wr_ptr_out)
    );

    gray_ptr_sync #(.SYNC_DEPTH(`DCFIFO_SYNC_DEPTH)) rd_crosser (
        .src_clk     (out_clk),
        .src_reset_n (out_reset_n),
        .dst_clk     (in_clk),
        .dst_reset_n (in_reset_n),
        .src_ptr     (rd_ptr_next),
        .dst_ptr     (rd_ptr_in)
    );

    dcfifo_read_side i_read_side (
        .out_clk     (out_clk),
        .out_reset_n (out_reset_n),
        .wr_ptr_sync (wr_ptr_out),
        .rd_ptr_next (rd_ptr_next),
        .rd_addr     (rd_addr),
        .ram_data    (ram_data),
        .out_data    (out_data),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .fill_level  (out_level)
    );

    // --------------------
    // CSR ports
    // --------------------
    level_csr #(.CMP(dcfifo_csr_pkg::CMP_AT_OR_ABOVE)) in_csr (
        .csr_clk       (in_clk),
        .csr_reset_n   (in_reset_n),
        .level         (in_level),
        .csr_address   (in_csr_address),
        .csr_read      (in_csr_read),
        .csr_write     (in_csr_write),
        .csr_writedata (in_csr_writedata),
        .csr_readdata  (in_csr_readdata),
        .status_valid  (almost_full_valid),
        .status_data   (almost_full_data)
    );

    level_csr #(.CMP(dcfifo_csr_pkg::CMP_AT_OR_BELOW)) out_csr (
        .csr_clk       (out_clk),
        .csr_reset_n   (out_reset_n),
        .level         (out_level),
        .csr_address   (out_csr_address),
        .csr_read      (out_csr_read),
        .csr_write     (out_csr_write),
        .csr_writedata (out_csr_writedata),
        .csr_readdata  (out_csr_readdata),
        .status_valid  (almost_empty_valid),
        .status_data   (almost_empty_data)
    );

endmodule

`default_nettype wire

/* src/dcfifo_write_side.sv */
/*
 * Input clock domain of the FIFO: write pointer, full flag and input fill level.
 * The read pointer arrives already synchronized and in binary.
 */
`timescale 1ns/1ps
`default_nettype none

`include "dcfifo_config.svh"

module dcfifo_write_side (
    input  logic                in_clk,
    input  logic                in_reset_n,
    input  logic                in_valid,
    output logic                in_ready,
    input  dcfifo_pkg::ptr_t    rd_ptr_sync,
    output dcfifo_pkg::ptr_t    wr_ptr,
    output logic                wr_en,
    output dcfifo_pkg::addr_t   wr_addr,
    output dcfifo_pkg::level_t  fill_level
);

    dcfifo_pkg::ptr_t wr_ptr_next;
    logic             full;
    logic             full_next;

    assign in_ready    = !full;
    assign wr_en       = in_valid && in_ready;
    assign wr_addr     = wr_ptr[`DCFIFO_ADDR_WIDTH-1:0];
    assign wr_ptr_next = wr_ptr + dcfifo_pkg::ptr_t'(wr_en);

    // Same address with opposite wrap bits
    assign full_next = (wr_ptr_next[`DCFIFO_ADDR_WIDTH-1:0] ==
                        rd_ptr_sync[`DCFIFO_ADDR_WIDTH-1:0]) &&
                       (wr_ptr_next[`DCFIFO_ADDR_WIDTH] != rd_ptr_sync[`DCFIFO_ADDR_WIDTH]);

    // --------------------
    // Pointer and flags
    // --------------------
    always_ff @(posedge in_clk or negedge in_reset_n) begin
        if (!in_reset_n) begin
            wr_ptr     <= '0;
            full       <= 1'b0;
            fill_level <= '0;
        end else begin
            wr_ptr <= wr_ptr_next;
            full   <= full_next;
            // Stored words only, the output stage is not seen from here
            fill_level <= wr_ptr_next - rd_ptr_sync;
        end
    end

endmodule

`default_nettype wire

/* src/gray_ptr_sync.sv */
/*
 * Moves a binary FIFO pointer into another clock domain.
 * Gray register on the source clock, flop chain and Gray-to-binary on the destination.
 */
`timescale 1ns/1ps
`default_nettype none

module gray_ptr_sync #(
    parameter int SYNC_DEPTH = 2
) (
    input  logic                src_clk,
    input  logic                src_reset_n,
    input  logic                dst_clk,
    input  logic                dst_reset_n,
    input  dcfifo_pkg::ptr_t    src_ptr,
    output dcfifo_pkg::ptr_t    dst_ptr
);

    localparam int TOP = $bits(dcfifo_pkg::ptr_t) - 1;

    dcfifo_pkg::ptr_t src_gray;
    dcfifo_pkg::ptr_t sync_q [SYNC_DEPTH];

    // Only one bit changes per increment, so sampling is safe
    always_ff @(posedge src_clk or negedge src_reset_n) begin
        if (!src_reset_n) begin
            src_gray <= '0;
        end else begin
            src_gray <= src_ptr ^ (src_ptr >> 1);
        end
    end

    always_ff @(posedge dst_clk or negedge dst_reset_n) begin
        if (!dst_reset_n) begin
            sync_q <= '{default: '0};
        end else begin
            sync_q[0] <= src_gray;
            for (int i = 1; i < SYNC_DEPTH; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    // Each binary bit is the XOR of all Gray bits above and at it
    always_comb begin
        dst_ptr[TOP] = sync_q[SYNC_DEPTH-1][TOP];
        for (int i = TOP - 1; i >= 0; i--) begin
            dst_ptr[i] = dst_ptr[i+1] ^ sync_q[SYNC_DEPTH-1][i];
        end
    end

endmodule

`default_nettype wire

/* src/level_csr.sv */
/*
 * Two-register CSR port of one FIFO side with its streaming status bit.
 * Address 0 reads the level, address 1 holds the threshold. CMP picks the status rule.
 */
`timescale 1ns/1ps
`default_nettype none

module level_csr #(
    parameter dcfifo_csr_pkg::thresh_cmp_e CMP = dcfifo_csr_pkg::CMP_AT_OR_ABOVE
) (
    input  logic                        csr_clk,
    input  logic                        csr_reset_n,
    input  dcfifo_pkg::level_t          level,
    input  dcfifo_csr_pkg::csr_addr_e   csr_address,
    input  logic                        csr_read,
    input  logic                        csr_write,
    input  dcfifo_csr_pkg::csr_word_t   csr_writedata,
    output dcfifo_csr_pkg::csr_word_t   csr_readdata,
    output logic                        status_valid,
    output logic                        status_data
);

    dcfifo_csr_pkg::threshold_t threshold;
    dcfifo_csr_pkg::threshold_t level_wide;
    dcfifo_csr_pkg::csr_word_t  read_word;
    logic                       level_hit;

    assign level_wide = dcfifo_csr_pkg::threshold_t'(level);

    // Upper bits of the read word stay zero
    assign read_word = (csr_address == dcfifo_csr_pkg::CSR_THRESHOLD) ?
                       dcfifo_csr_pkg::csr_word_t'(threshold) :
                       dcfifo_csr_pkg::csr_word_t'(level_wide);

    assign level_hit = (CMP == dcfifo_csr_pkg::CMP_AT_OR_ABOVE) ?
                       (level_wide >= threshold) : (level_wide <= threshold);

    // --------------------
    // Register access
    // --------------------
    always_ff @(posedge csr_clk or negedge csr_reset_n) begin
        if (!csr_reset_n) begin
            threshold    <= '0;
            csr_readdata <= '0;
        end else if (csr_write) begin
            // Level register is read only
            if (csr_address == dcfifo_csr_pkg::CSR_THRESHOLD) begin
                threshold <= dcfifo_csr_pkg::threshold_t'(csr_writedata);
            end
        end else if (csr_read) begin
            csr_readdata <= read_word;
        end
    end

    // --------------------
    // Streaming status
    // --------------------
    always_ff @(posedge csr_clk or negedge csr_reset_n) begin
        if (!csr_reset_n) begin
            status_valid <= 1'b0;
            status_data  <= 1'b0;
        end else begin
            status_valid <= 1'b1;
            status_data  <= level_hit;
        end
    end

endmodule

`default_nettype wire

/* tests/dcfifo_properties.sv */
/*
 * Concurrent checks on the FIFO top level, attached to dcfifo_top with bind.
 */
`timescale 1ns/1ps
`default_nettype none

module dcfifo_properties (
    input logic                         in_clk,
    input logic                         in_reset_n,
    input logic                         out_clk,
    input logic                         out_reset_n,
    input logic                         in_ready,
    input logic                         wr_en,
    input dcfifo_pkg::ptr_t             wr_ptr,
    input dcfifo_pkg::ptr_t             rd_ptr_in,
    input logic                         out_valid,
    input logic                         out_ready,
    input dcfifo_pkg::data_t            out_data,
    input dcfifo_csr_pkg::csr_word_t    in_csr_readdata,
    input dcfifo_csr_pkg::csr_word_t    out_csr_readdata
);

    localparam int DEPTH = 2 ** $bits(dcfifo_pkg::addr_t);

    // Writing while DEPTH words are unread would overwrite the oldest one
    no_write_when_full: assert property (
        @(posedge in_clk) disable iff (!in_reset_n)
        wr_en |-> (dcfifo_pkg::ptr_t'(wr_ptr - rd_ptr_in) != dcfifo_pkg::ptr_t'(DEPTH))
    ) else $error("word written into the memory while the FIFO was full");

    // A stalled word stays on the bus unchanged
    data_stable_when_stalled: assert property (
        @(posedge out_clk) disable iff (!out_reset_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data))
    ) else $error("out_data or out_valid changed while the source was stalled");

    out_valid_low_after_reset: assert property (
        @(posedge out_clk) $rose(out_reset_n) |-> !out_valid
    ) else $error("out_valid high on the first out_clk edge after reset");

    // --------------------
    // CSR read data
    // --------------------
    in_csr_upper_zero: assert property (
        @(posedge in_clk) in_csr_readdata[31:24] == 8'h00
    ) else $error("in CSR read data has nonzero upper byte");

    out_csr_upper_zero: assert property (
        @(posedge out_clk) out_csr_readdata[31:24] == 8'h00
    ) else $error("out CSR read data has nonzero upper byte");

endmodule

bind dcfifo_top dcfifo_properties i_properties (
    .in_clk           (in_clk),
    .in_reset_n       (in_reset_n),
    .out_clk          (out_clk),
    .out_reset_n      (out_reset_n),
    .in_ready         (in_ready),
    .wr_en            (wr_en),
    .wr_ptr           (wr_ptr),
    .rd_ptr_in        (rd_ptr_in),
    .out_valid        (out_valid),
    .out_ready        (out_ready),
    .out_data         (out_data),
    .in_csr_readdata  (in_csr_readdata),
    .out_csr_readdata (out_csr_readdata)
);

`default_nettype wire

/* tests/tb_dcfifo.sv */
/*
 * Testbench for the dual-clock stream FIFO. Random and stalled traffic,
 * CSR access and status rules, checked against a queue model.
 */
`timescale 1ns/1ps
`default_nettype none

`include "dcfifo_config.svh"

module tb_dcfifo;

    localparam int DEPTH         = 1 << `DCFIFO_ADDR_WIDTH;
    localparam int N_RANDOM      = 300;
    localparam int STATUS_WORDS  = 16;
    localparam int PLANNED_WORDS = N_RANDOM + 1 + DEPTH + STATUS_WORDS;
    localparam int SETTLE_CYCLES = 30;
    localparam int READY_LOW     = 0;
    localparam int READY_HIGH    = 1;
    localparam int READY_RANDOM  = 2;
    localparam dcfifo_csr_pkg::csr_word_t IN_THRESH_WORD  = 32'hAB00_000A;
    localparam dcfifo_csr_pkg::csr_word_t OUT_THRESH_WORD = 32'hFF00_0003;

    logic                       in_clk;
    logic                       in_reset_n;
    logic                       out_clk;
    logic                       out_reset_n;
    dcfifo_pkg::data_t          in_data;
    logic                       in_valid;
    logic                       in_ready;
    dcfifo_pkg::data_t          out_data;
    logic                       out_valid;
    logic                       out_ready;
    dcfifo_csr_pkg::csr_addr_e  in_csr_address;
    logic                       in_csr_read;
    logic                       in_csr_write;
    dcfifo_csr_pkg::csr_word_t  in_csr_writedata;
    dcfifo_csr_pkg::csr_word_t  in_csr_readdata;
    dcfifo_csr_pkg::csr_addr_e  out_csr_address;
    logic                       out_csr_read;
    logic                       out_csr_write;
    dcfifo_csr_pkg::csr_word_t  out_csr_writedata;
    dcfifo_csr_pkg::csr_word_t  out_csr_readdata;
    logic                       almost_full_valid;
    logic                       almost_full_data;
    logic                       almost_empty_valid;
    logic                       almost_empty_data;

    integer            in_seed;
    integer            out_seed;
    int                ready_mode;
    int                sent_total;
    int                received;
    int                in_thresh;
    int                out_thresh;
    string             test_name;
    dcfifo_pkg::data_t expected_q[$];
    int                status_steps[4] = '{3, 6, 2, 5};

    dcfifo_top i_dcfifo_top (.*);

    initial begin
        in_clk = 1'b0;
        forever #5 in_clk = ~in_clk;
    end

    initial begin
        out_clk = 1'b0;
        forever #7 out_clk = ~out_clk;
    end

    // --------------------
    // Reporting
    // --------------------
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_data(input string name, input dcfifo_pkg::data_t expected,
                              input dcfifo_pkg::data_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH %s: expected 0x%0h, actual 0x%0h",
                                name, expected, actual));
        end
    endtask

    task automatic check_csr(input string name, input dcfifo_csr_pkg::csr_word_t expected,
                             input dcfifo_csr_pkg::csr_word_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH %s: expected 0x%0h, actual 0x%0h",
                                name, expected, actual));
        end
    endtask

    task automatic check_status(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    // CSR word of a level or threshold, bits above 23 read as zero
    function automatic dcfifo_csr_pkg::csr_word_t expected_csr(input int unsigned value);
        return dcfifo_csr_pkg::csr_word_t'(value & 32'h00FF_FFFF);
    endfunction

    // --------------------
    // Stimulus
    // --------------------
    task automatic send_words(input int count, input bit random_valid);
        int sent;
        sent = 0;
        while (sent < count) begin
            @(posedge in_clk);
            if (in_valid && in_ready) begin
                expected_q.push_back(in_data);
                sent++;
                sent_total++;
            end
            if (sent == count) begin
                in_valid <= 1'b0;
            end else if (!in_valid || in_ready) begin
                in_valid <= random_valid ? (($random(in_seed) & 3) != 0) : 1'b1;
                in_data  <= dcfifo_pkg::data_t'(sent_total * 37 + 5);
            end
        end
    endtask

    task automatic in_csr_cycle(input logic wr, input dcfifo_csr_pkg::csr_addr_e addr,
                                input dcfifo_csr_pkg::csr_word_t wdata,
                                output dcfifo_csr_pkg::csr_word_t rdata);
        @(posedge in_clk);
        in_csr_address   <= addr;
        in_csr_writedata <= wdata;
        in_csr_write     <= wr;
        in_csr_read      <= !wr;
        @(posedge in_clk);
        in_csr_write <= 1'b0;
        in_csr_read  <= 1'b0;
        @(posedge in_clk);
        rdata = in_csr_readdata;
    endtask

    task automatic out_csr_cycle(input logic wr, input dcfifo_csr_pkg::csr_addr_e addr,
                                 input dcfifo_csr_pkg::csr_word_t wdata,
                                 output dcfifo_csr_pkg::csr_word_t rdata);
        @(posedge out_clk);
        out_csr_address   <= addr;
        out_csr_writedata <= wdata;
        out_csr_write     <= wr;
        out_csr_read      <= !wr;
        @(posedge out_clk);
        out_csr_write <= 1'b0;
        out_csr_read  <= 1'b0;
        @(posedge out_clk);
        rdata = out_csr_readdata;
    endtask

    // Stalled source: the output stage holds one word, the input level excludes it
    task automatic check_levels(input string name);
        int                        held;
        int                        in_exp;
        dcfifo_csr_pkg::csr_word_t word;
        held   = expected_q.size();
        in_exp = (held > 0) ? held - 1 : 0;
        repeat (SETTLE_CYCLES) @(posedge in_clk);
        in_csr_cycle(1'b0, dcfifo_csr_pkg::CSR_FILL_LEVEL, '0, word);
        check_csr({name, " in level"}, expected_csr(in_exp), word);
        out_csr_cycle(1'b0, dcfifo_csr_pkg::CSR_FILL_LEVEL, '0, word);
        check_csr({name, " out level"}, expected_csr(held), word);
        @(posedge in_clk);
        check_status({name, " almost full"}, in_exp >= in_thresh, almost_full_data);
        @(posedge out_clk);
        check_status({name, " almost empty"}, held <= out_thresh, almost_empty_data);
    endtask

    always @(posedge out_clk) begin
        case (ready_mode)
            READY_LOW:  out_ready <= 1'b0;
            READY_HIGH: out_ready <= 1'b1;
            default:    out_ready <= (($random(out_seed) & 1) != 0);
        endcase
    end

    // Every output transfer takes the oldest accepted word
    always @(posedge out_clk) begin
        if (out_reset_n && out_valid && out_ready) begin
            if (expected_q.size() == 0) begin
                abort_run("output transfer with no word left in the reference queue");
            end else begin
                check_data(test_name, expected_q.pop_front(), out_data);
                received++;
            end
        end
    end

    initial begin
        repeat (PLANNED_WORDS * 200 + 2000) @(posedge in_clk);
        abort_run("timeout: the run did not finish within its cycle budget");
    end

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        dcfifo_csr_pkg::csr_word_t word;
        in_seed           = 24693;
        out_seed          = 24693;
        ready_mode        = READY_LOW;
        sent_total        = 0;
        received          = 0;
        in_thresh         = 0;
        out_thresh        = 0;
        test_name         = "reset";
        in_reset_n        = 1'b0;
        out_reset_n       = 1'b0;
        in_data           = '0;
        in_valid          = 1'b0;
        out_ready         = 1'b0;
        in_csr_address    = dcfifo_csr_pkg::CSR_FILL_LEVEL;
        in_csr_read       = 1'b0;
        in_csr_write      = 1'b0;
        in_csr_writedata  = '0;
        out_csr_address   = dcfifo_csr_pkg::CSR_FILL_LEVEL;
        out_csr_read      = 1'b0;
        out_csr_write     = 1'b0;
        out_csr_writedata = '0;
        fork
            begin
                repeat (3) @(posedge in_clk);
                in_reset_n <= 1'b1;
                @(posedge in_clk);
                check_status("in_ready after reset", 1'b1, in_ready);
                check_status("almost_full_valid after reset", 1'b0, almost_full_valid);
                @(posedge in_clk);
                check_status("almost_full_valid one cycle later", 1'b1, almost_full_valid);
            end
            begin
                repeat (3) @(posedge out_clk);
                out_reset_n <= 1'b1;
                @(posedge out_clk);
                check_status("out_valid after reset", 1'b0, out_valid);
                check_status("almost_empty_valid after reset", 1'b0, almost_empty_valid);
                @(posedge out_clk);
                check_status("almost_empty_valid one cycle later", 1'b1, almost_empty_valid);
            end
        join

        test_name  = "ordered transfer";
        ready_mode = READY_RANDOM;
        send_words(N_RANDOM, 1'b1);
        wait (received == sent_total);

        // First word settles in the output stage, then the memory fills
        test_name  = "fill under back-pressure";
        ready_mode = READY_LOW;
        repeat (3) @(posedge out_clk);
        send_words(1, 1'b0);
        wait (out_valid === 1'b1);
        send_words(DEPTH, 1'b0);
        repeat (SETTLE_CYCLES) begin
            @(posedge in_clk);
            check_status(test_name, 1'b0, in_ready);
            in_valid <= 1'b1;
        end
        in_valid <= 1'b0;
        check_levels(test_name);
        ready_mode = READY_HIGH;
        wait (received == sent_total);
        repeat (SETTLE_CYCLES) @(posedge in_clk);
        check_status("in_ready after drain", 1'b1, in_ready);

        test_name = "thresholds";
        in_csr_cycle(1'b1, dcfifo_csr_pkg::CSR_THRESHOLD, IN_THRESH_WORD, word);
        in_thresh = int'(expected_csr(IN_THRESH_WORD));
        out_csr_cycle(1'b1, dcfifo_csr_pkg::CSR_THRESHOLD, OUT_THRESH_WORD, word);
        out_thresh = int'(expected_csr(OUT_THRESH_WORD));
        // Level register is read only
        in_csr_cycle(1'b1, dcfifo_csr_pkg::CSR_FILL_LEVEL, 32'h0000_0055, word);
        out_csr_cycle(1'b1, dcfifo_csr_pkg::CSR_FILL_LEVEL, 32'h0000_0055, word);
        in_csr_cycle(1'b0, dcfifo_csr_pkg::CSR_THRESHOLD, '0, word);
        check_csr("in threshold", expected_csr(IN_THRESH_WORD), word);
        out_csr_cycle(1'b0, dcfifo_csr_pkg::CSR_THRESHOLD, '0, word);
        check_csr("out threshold", expected_csr(OUT_THRESH_WORD), word);

        test_name  = "status rules";
        ready_mode = READY_LOW;
        repeat (3) @(posedge out_clk);
        check_levels("status at 0 words");
        foreach (status_steps[i]) begin
            send_words(status_steps[i], 1'b0);
            check_levels($sformatf("status at %0d words", expected_q.size()));
        end
        ready_mode = READY_HIGH;
        wait (received == sent_total);
        repeat (SETTLE_CYCLES) @(posedge in_clk);

        if (expected_q.size() == 0 && received == sent_total) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            abort_run("words left in the reference queue at the end of the run");
        end
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+src
src/dcfifo_pkg.sv
src/dcfifo_csr_pkg.sv
src/gray_ptr_sync.sv
src/dcfifo_ram.sv
src/dcfifo_write_side.sv
src/dcfifo_read_side.sv
src/level_csr.sv
src/dcfifo_top.sv
tests/dcfifo_properties.sv
tests/tb_dcfifo.sv
